/* hdl/rv_pkg.sv */
// RV32I subset pipeline shared widths, encodings and stage records
package rv_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int dmem_words  = 256;
  localparam int dmem_addr_w = $clog2(dmem_words); // Word index bits

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add    = 3'd0,  // Also address calc for lw and sw
    alu_sub    = 3'd1,
    alu_and    = 3'd2,
    alu_or     = 3'd3,
    alu_xor    = 3'd4,
    alu_slt    = 3'd5,
    alu_pass_b = 3'd6   // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none     = 2'd0,
    fwd_from_mem = 2'd1,
    fwd_from_wb  = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;
    alu_op_t               alu_op;
    logic                  alu_src;   // 1 selects imm as ALU operand b
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  branch;
    logic                  branch_ne; // bne when set, beq otherwise
    logic                  is_jal;
    logic                  is_ecall;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       result;     // ALU result, address or link
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  is_ecall;   // Sets the sticky halt in memory
  } ex_mem_t;

  // Write-back record, doubles as the retire record
  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       data;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
  } mem_wb_t;

endpackage

/* hdl/rv_regfile.sv */
// Register file, 32 x xlen, x0 hardwired to zero, write-through reads
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  rv_pkg::mem_wb_t               wb
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];
  logic            wr_en;

  assign wr_en = wb.valid & wb.reg_write & (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Bypass covers the write-back to decode distance
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_en && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_en && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

endmodule

/* hdl/rv_hazard.sv */
// Hazard unit, load-use stall and execute operand forwarding selects
`timescale 1ns/1ps

module rv_hazard (
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  rv_pkg::id_ex_t                id_ex,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_mem_rd,
  input  logic                          ex_mem_write,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic                          wb_write,
  output logic                          stall,
  output rv_pkg::fwd_sel_t              fwd_a,
  output rv_pkg::fwd_sel_t              fwd_b
);
  import rv_pkg::*;

  // Memory stage checked first so the newest producer wins
  function automatic fwd_sel_t pick_src(input logic [reg_addr_w-1:0] src);
    if (src == '0) return fwd_none;  // x0 never forwards
    if (ex_mem_write && ex_mem_rd == src) return fwd_from_mem;
    if (wb_write && wb_rd == src) return fwd_from_wb;
    return fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick_src(id_ex.rs1);
    fwd_b = pick_src(id_ex.rs2);
  end

  // Load data only exists after memory, so a direct consumer waits a cycle
  assign stall = id_ex.valid & id_ex.mem_read & (id_ex.rd != '0) &
                 ((id_ex.rd == rs1_addr) | (id_ex.rd == rs2_addr));

endmodule

/* hdl/rv_fetch.sv */
// Fetch stage, PC update with redirect and freeze, fetch/decode register
`timescale 1ns/1ps

module rv_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_target,
  input  logic                    halt_freeze,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] imem_data,
  output rv_pkg::if_id_t          if_id
);
  import rv_pkg::*;

  logic [xlen-1:0] pc;

  assign imem_addr = pc;  // Combinational fetch port

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      if_id.valid <= 1'b0;
    end else begin
      // Freeze wins over the ecall redirect in the same cycle
      if (halt_freeze) pc <= pc;
      else if (redirect) pc <= redirect_target;
      else if (!stall) pc <= pc + xlen'(4);

      if (redirect || halt_freeze) begin
        if_id.valid <= 1'b0;  // Wrong path or post-ecall slot
      end else if (!stall) begin
        if_id.valid <= 1'b1;
        if_id.pc    <= pc;
        if_id.instr <= imem_data;
      end
    end
  end

endmodule

/* hdl/rv_decode.sv */
// Decode stage, control and immediate decode into the decode/execute register
`timescale 1ns/1ps

module rv_decode (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_pkg::if_id_t                if_id,
  input  logic                          stall,
  input  logic                          redirect,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  output rv_pkg::id_ex_t                id_ex
);
  import rv_pkg::*;

  logic [xlen-1:0] instr;
  opcode_t         opc;
  logic [2:0]      funct3;
  alu_op_t         f3_op;  // Shared R/I-type funct3 mapping
  logic            f3_ok;
  logic            known;
  id_ex_t          nxt;

  assign instr    = if_id.instr;
  assign opc      = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      3'b000:  f3_op = alu_add;
      3'b111:  f3_op = alu_and;
      3'b110:  f3_op = alu_or;
      3'b100:  f3_op = alu_xor;
      3'b010:  f3_op = alu_slt;
      default: begin
        f3_op = alu_add;
        f3_ok = 1'b0;  // Shifts and sltu not supported
      end
    endcase
  end

  always_comb begin
    nxt         = '0;
    known       = 1'b1;
    nxt.pc      = if_id.pc;
    nxt.rs1     = rs1_addr;
    nxt.rs2     = rs2_addr;
    nxt.rs1_val = rs1_data;
    nxt.rs2_val = rs2_data;
    nxt.rd      = instr[11:7];
    case (opc)
      opc_op: begin
        nxt.reg_write = 1'b1;
        nxt.alu_op    = (funct3 == 3'b000 && instr[30]) ? alu_sub : f3_op;
        known         = f3_ok;
      end
      opc_op_imm: begin
        nxt.reg_write = 1'b1;
        nxt.alu_src   = 1'b1;
        nxt.alu_op    = f3_op;
        nxt.imm       = {{20{instr[31]}}, instr[31:20]};
        known         = f3_ok;
      end
      opc_lui: begin
        nxt.reg_write = 1'b1;
        nxt.alu_src   = 1'b1;
        nxt.alu_op    = alu_pass_b;
        nxt.imm       = {instr[31:12], 12'b0};
      end
      opc_load: begin
        nxt.reg_write = 1'b1;
        nxt.mem_read  = 1'b1;
        nxt.alu_src   = 1'b1;
        nxt.imm       = {{20{instr[31]}}, instr[31:20]};
        known         = (funct3 == 3'b010);  // lw only
      end
      opc_store: begin
        nxt.mem_write = 1'b1;
        nxt.alu_src   = 1'b1;
        nxt.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        known         = (funct3 == 3'b010);  // sw only
      end
      opc_branch: begin
        nxt.branch    = 1'b1;
        nxt.branch_ne = funct3[0];
        nxt.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
        known         = (funct3[2:1] == 2'b00);  // beq, bne
      end
      opc_jal: begin
        nxt.reg_write = 1'b1;
        nxt.is_jal    = 1'b1;
        nxt.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
      end
      opc_system: nxt.is_ecall = 1'b1;
      default:    known = 1'b0;
    endcase
    nxt.valid = if_id.valid & known & ~stall & ~redirect;
    if (!nxt.valid) begin  // Bubble carries no side effects
      nxt.reg_write = 1'b0;
      nxt.mem_read  = 1'b0;
      nxt.mem_write = 1'b0;
      nxt.branch    = 1'b0;
      nxt.is_jal    = 1'b0;
      nxt.is_ecall  = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) id_ex <= '0;
    else id_ex <= nxt;
  end

endmodule

/* hdl/rv_execute.sv */
// Execute stage, operand forwarding, ALU, branch and jump resolution, ecall freeze
`timescale 1ns/1ps

module rv_execute (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::id_ex_t          id_ex,
  input  rv_pkg::fwd_sel_t        fwd_a,
  input  rv_pkg::fwd_sel_t        fwd_b,
  input  logic [rv_pkg::xlen-1:0] mem_result,
  input  logic [rv_pkg::xlen-1:0] wb_result,
  output logic                    redirect,
  output logic [rv_pkg::xlen-1:0] redirect_target,
  output logic                    halt_freeze,
  output rv_pkg::ex_mem_t         ex_mem
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b_reg;  // rs2 after forwarding, also store data
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_out;
  logic            taken;
  logic            frozen;    // Sticky after the first ecall

  always_comb begin
    case (fwd_a)
      fwd_from_mem: op_a = mem_result;
      fwd_from_wb:  op_a = wb_result;
      default:      op_a = id_ex.rs1_val;
    endcase
    case (fwd_b)
      fwd_from_mem: op_b_reg = mem_result;
      fwd_from_wb:  op_b_reg = wb_result;
      default:      op_b_reg = id_ex.rs2_val;
    endcase
  end

  assign op_b = id_ex.alu_src ? id_ex.imm : op_b_reg;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub:    alu_out = op_a - op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_or:     alu_out = op_a | op_b;
      alu_xor:    alu_out = op_a ^ op_b;
      alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_pass_b: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // Branch compare on forwarded register values, not the ALU operand
  assign taken = id_ex.branch & (id_ex.branch_ne ^ (op_a == op_b_reg));
  assign redirect = id_ex.valid & (taken | id_ex.is_jal | id_ex.is_ecall);
  assign redirect_target = id_ex.pc + id_ex.imm;  // Ignored by fetch on ecall
  assign halt_freeze = frozen | (id_ex.valid & id_ex.is_ecall);

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
      frozen <= 1'b0;
    end else begin
      if (id_ex.valid && id_ex.is_ecall) frozen <= 1'b1;
      ex_mem.valid      <= id_ex.valid;
      ex_mem.result     <= id_ex.is_jal ? id_ex.pc + xlen'(4) : alu_out;  // Link
      ex_mem.store_data <= op_b_reg;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.is_ecall   <= id_ex.is_ecall;
    end
  end

endmodule

/* hdl/rv_memory.sv */
// Memory stage, single-cycle word data memory and the memory/write-back register
`timescale 1ns/1ps

module rv_memory (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::mem_wb_t mem_wb,
  output logic            is_halted
);
  import rv_pkg::*;

  logic [xlen-1:0]        dmem [dmem_words];
  logic [dmem_addr_w-1:0] word_idx;
  logic [xlen-1:0]        rdata;

  assign word_idx = ex_mem.result[dmem_addr_w+1:2];  // Drop byte offset
  assign rdata    = dmem[word_idx];                  // Combinational read

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) dmem[word_idx] <= ex_mem.store_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb    <= '0;
      is_halted <= 1'b0;
    end else begin
      if (ex_mem.valid && ex_mem.is_ecall) is_halted <= 1'b1;  // Until reset
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.data      <= ex_mem.mem_read ? rdata : ex_mem.result;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.reg_write <= ex_mem.reg_write;
    end
  end

endmodule

/* hdl/rv_pipeline.sv */
// Five-stage RV32I subset processor top, stage and hazard wiring plus retire port
`timescale 1ns/1ps

module rv_pipeline (
  input  logic                          clk,
  input  logic                          reset,
  output logic [rv_pkg::xlen-1:0]       imem_addr,
  input  logic [rv_pkg::xlen-1:0]       imem_data,
  output logic                          retire_valid,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic                          is_halted
);
  import rv_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;
  logic                  stall;        // Load-use hold of fetch and decode
  logic                  redirect;     // One-cycle flush pulse from execute
  logic [xlen-1:0]       redirect_target;
  logic                  halt_freeze;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  fwd_sel_t              fwd_a;
  fwd_sel_t              fwd_b;

  rv_fetch u_fetch (
    .clk(clk), .reset(reset), .stall(stall),
    .redirect(redirect), .redirect_target(redirect_target),
    .halt_freeze(halt_freeze),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .if_id(if_id)
  );

  rv_decode u_decode (
    .clk(clk), .reset(reset), .if_id(if_id),
    .stall(stall), .redirect(redirect),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .id_ex(id_ex)
  );

  rv_execute u_execute (
    .clk(clk), .reset(reset), .id_ex(id_ex),
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .mem_result(ex_mem.result),  // Newest value, one instruction older
    .wb_result(mem_wb.data),     // Two instructions older, load data included
    .redirect(redirect), .redirect_target(redirect_target),
    .halt_freeze(halt_freeze), .ex_mem(ex_mem)
  );

  rv_memory u_memory (
    .clk(clk), .reset(reset), .ex_mem(ex_mem),
    .mem_wb(mem_wb), .is_halted(is_halted)
  );

  rv_regfile u_regfile (
    .clk(clk), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb(mem_wb)
  );

  rv_hazard u_hazard (
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .id_ex(id_ex),
    .ex_mem_rd(ex_mem.rd), .ex_mem_write(ex_mem.valid & ex_mem.reg_write),
    .wb_rd(mem_wb.rd), .wb_write(mem_wb.valid & mem_wb.reg_write),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  // Only real register writes retire, x0 targets are dropped
  assign retire_valid = mem_wb.valid & mem_wb.reg_write & (mem_wb.rd != '0);
  assign retire_rd    = mem_wb.rd;
  assign retire_data  = mem_wb.data;

endmodule

/* testbench/rv_tb_properties.sv */
// Retire and halt port checks, bound into the pipeline top
`timescale 1ns/1ps

module rv_tb_properties (
  input logic       clk,
  input logic       reset,
  input logic       retire_valid,
  input logic [4:0] retire_rd,
  input logic       is_halted
);

  // Nothing retires in the first cycle after reset
  after_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !retire_valid)
    else $error("retire_valid high in the cycle after reset");

  rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire_rd != 5'd0)
    else $error("retire with rd of zero");

  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted)
    else $error("is_halted dropped without reset");

  no_retire_halted: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> !retire_valid)
    else $error("retire while halted");

endmodule

bind rv_pipeline rv_tb_properties props_i (
  .clk(clk), .reset(reset), .retire_valid(retire_valid),
  .retire_rd(retire_rd), .is_halted(is_halted)
);

/* testbench/rv_tb.sv */
// Pipeline testbench, program ROM, ISA reference model and retire checker
`timescale 1ns/1ps

module rv_tb;
  import rv_pkg::*;

  localparam logic [31:0] ecall_w = 32'h00000073;

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        is_halted;

  logic [31:0] prog [256];
  int          prog_len;
  logic [31:0] mdl_mem [16];  // Model data words, persist like the DUT memory
  logic [4:0]  exp_rd [2048];
  logic [31:0] exp_val [2048];
  int          exp_cnt;
  int          ret_cnt;
  int          errors;
  int          tests;
  int          failed;
  logic [31:0] lcg_state;

  rv_pipeline rv_pipeline_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Past the program end the ROM answers ecall
  always_comb begin
    if (imem_addr[31:2] < prog_len) imem_data = prog[imem_addr[9:2]];
    else imem_data = ecall_w;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[30:15]};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [11:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // ISA model, fills the expected write trace up to the first ecall
  function automatic int run_model();
    logic [31:0] r [32];
    logic [31:0] pc, ins, a, b, res, imm_i;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    int          n;
    n = 0;
    pc = 0;
    for (int i = 0; i < 32; i++) r[i] = 0;
    for (int step = 0; step < 2000; step++) begin
      ins   = (pc[31:2] < prog_len) ? prog[pc[9:2]] : ecall_w;
      f3    = ins[14:12];
      rd    = ins[11:7];
      a     = r[ins[19:15]];
      b     = r[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      wr    = 1'b1;
      res   = 0;
      if (ins[6:0] == opc_system) break;
      case (ins[6:0])
        opc_op, opc_op_imm: begin
          if (ins[6:0] == opc_op_imm) b = imm_i;
          case (f3)
            3'b000:  res = (ins[6:0] == opc_op && ins[30]) ? a - b : a + b;
            3'b111:  res = a & b;
            3'b110:  res = a | b;
            3'b100:  res = a ^ b;
            default: res = ($signed(a) < $signed(b)) ? 1 : 0;  // slt
          endcase
        end
        opc_lui:  res = {ins[31:12], 12'd0};
        opc_load: res = mdl_mem[(a + imm_i) >> 2];
        opc_store: begin
          mdl_mem[(a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2] = b;
          wr = 1'b0;
        end
        opc_branch: wr = 1'b0;
        default:  res = pc + 4;  // jal link
      endcase
      if (wr && rd != 0) begin
        r[rd] = res;
        exp_rd[n] = rd;
        exp_val[n] = res;
        n++;
      end
      if (ins[6:0] == opc_jal) begin
        pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end else if (ins[6:0] == opc_branch && ((a == b) ^ f3[0])) begin
        pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end else begin
        pc = pc + 4;
      end
    end
    return n;
  endfunction

  // Retire checker, outputs settle after the rising edge
  always @(negedge clk) begin
    if (retire_valid === 1'b1) begin
      if (is_halted) begin
        $display("Register write retired after the halt at %0t", $time);
        errors++;
      end
      if (ret_cnt >= exp_cnt) begin
        $display("Unexpected extra retire of x%0d at %0t", retire_rd, $time);
        errors++;
      end else if (retire_rd !== exp_rd[ret_cnt] || retire_data !== exp_val[ret_cnt]) begin
        $display("Mismatch at %0t: retire %0d got x%0d=%h, expected x%0d=%h", $time,
                 ret_cnt, retire_rd, retire_data, exp_rd[ret_cnt], exp_val[ret_cnt]);
        errors++;
      end
      ret_cnt++;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_program(input string name);
    int err0;
    int cyc;
    err0 = errors;
    exp_cnt = run_model();
    ret_cnt = 0;
    apply_reset();
    for (cyc = 0; cyc < 3000 && is_halted !== 1'b1; cyc++) @(negedge clk);
    if (is_halted !== 1'b1) begin
      $display("Timed out waiting for the halt in %s", name);
      errors++;
    end
    for (cyc = 0; cyc < 10; cyc++) @(negedge clk);  // Watch for late writes
    if (ret_cnt != exp_cnt) begin
      $display("Mismatch at %0t: %s retired %0d writes, expected %0d", $time, name,
               ret_cnt, exp_cnt);
      errors++;
    end
    tests++;
    if (errors != err0) failed++;
    $display("test %s: %s", name, (errors == err0) ? "ok" : "failed");
  endtask

  task automatic build_random();
    logic [31:0] k;
    logic [31:0] v;
    logic [2:0]  f3;
    logic [4:0]  rd, s1, s2;
    int          skip;
    prog_len = 0;
    for (int w = 0; w < 16; w++) emit(enc_s(12'(w * 4), 5'd0, 5'd0));  // Defined memory
    for (int i = 0; i < 24; i++) begin
      k  = next_rand() % 8;
      rd = 5'(1 + next_rand() % 7);
      s1 = 5'(next_rand() % 8);
      s2 = 5'(next_rand() % 8);
      skip = 1 + next_rand() % 3;
      if (i + skip + 1 > 24) skip = 24 - i - 1;
      case (k)
        0, 1, 2: begin
          case (next_rand() % 6)
            0: emit(enc_r(7'h00, s2, s1, 3'b000, rd));
            1: emit(enc_r(7'h20, s2, s1, 3'b000, rd));
            2: emit(enc_r(7'h00, s2, s1, 3'b111, rd));
            3: emit(enc_r(7'h00, s2, s1, 3'b110, rd));
            4: emit(enc_r(7'h00, s2, s1, 3'b100, rd));
            default: emit(enc_r(7'h00, s2, s1, 3'b010, rd));
          endcase
        end
        3: begin
          case (next_rand() % 5)  // Shifts and sltiu are outside the subset
            0: f3 = 3'b000;
            1: f3 = 3'b111;
            2: f3 = 3'b110;
            3: f3 = 3'b100;
            default: f3 = 3'b010;
          endcase
          emit(enc_i(opc_op_imm, 12'(next_rand()), s1, f3, rd));
        end
        4: begin
          v = (next_rand() << 16) | next_rand();  // Full 20-bit upper immediate
          emit({v[19:0], rd, 7'b0110111});
        end
        5: emit(enc_s(12'((next_rand() % 16) * 4), s2, 5'd0));
        6: emit(enc_i(opc_load, 12'((next_rand() % 16) * 4), 5'd0, 3'b010, rd));
        default: begin
          if (skip == 0) emit(enc_i(opc_op_imm, 12'd1, s1, 3'b000, rd));
          else if (next_rand() % 3 == 0) emit(enc_j(21'((skip + 1) * 4), rd));
          else emit(enc_b(13'((skip + 1) * 4), s2, s1, 3'(next_rand() % 2)));
        end
      endcase
    end
    emit(ecall_w);
  endtask

  initial begin
    reset = 1'b1;
    prog_len = 0;
    errors = 0;
    tests = 0;
    failed = 0;
    exp_cnt = 0;
    ret_cnt = 0;
    lcg_state = 32'd38;
    for (int w = 0; w < 16; w++) mdl_mem[w] = 0;

    // Reset state
    emit(ecall_w);
    apply_reset();
    if (imem_addr !== 0 || retire_valid !== 1'b0 || is_halted !== 1'b0) begin
      $display("Mismatch at %0t: after reset pc=%h retire=%b halt=%b", $time,
               imem_addr, retire_valid, is_halted);
      errors++;
      failed++;
    end
    tests++;
    $display("test reset: %s", (errors == 0) ? "ok" : "failed");

    prog_len = 0;  // ALU chain, forwarding from both stages
    emit(enc_i(opc_op_imm, 12'd5, 5'd0, 3'b000, 5'd1));
    emit(enc_i(opc_op_imm, 12'd7, 5'd1, 3'b000, 5'd2));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(enc_i(opc_op_imm, 12'hff0, 5'd0, 3'b000, 5'd5));
    emit(enc_r(7'h00, 5'd4, 5'd5, 3'b010, 5'd6));
    emit(enc_r(7'h00, 5'd5, 5'd3, 3'b111, 5'd7));
    emit(enc_r(7'h00, 5'd7, 5'd6, 3'b110, 5'd8));
    emit(enc_r(7'h00, 5'd8, 5'd5, 3'b100, 5'd9));
    emit({20'habcde, 5'd10, 7'b0110111});
    emit(enc_i(opc_op_imm, 12'h123, 5'd10, 3'b100, 5'd11));
    emit(enc_i(opc_op_imm, 12'h7ff, 5'd11, 3'b010, 5'd12));
    emit(enc_i(opc_op_imm, 12'h0f0, 5'd11, 3'b111, 5'd13));
    emit(enc_i(opc_op_imm, 12'h00f, 5'd13, 3'b110, 5'd14));
    emit(ecall_w);
    run_program("alu");

    prog_len = 0;  // Stores, loads and a load-use pair
    emit(enc_i(opc_op_imm, 12'd100, 5'd0, 3'b000, 5'd1));
    emit(enc_i(opc_op_imm, 12'hffd, 5'd0, 3'b000, 5'd2));
    emit(enc_s(12'd8, 5'd1, 5'd0));
    emit(enc_s(12'd12, 5'd2, 5'd0));
    emit(enc_i(opc_load, 12'd8, 5'd0, 3'b010, 5'd3));
    emit(enc_r(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(enc_i(opc_load, 12'd12, 5'd0, 3'b010, 5'd5));
    emit(enc_s(12'd16, 5'd5, 5'd0));
    emit(enc_i(opc_load, 12'd16, 5'd0, 3'b010, 5'd6));
    emit(enc_r(7'h00, 5'd4, 5'd6, 3'b010, 5'd7));
    emit(ecall_w);
    run_program("memory");

    prog_len = 0;  // Branches and jal, flushed slots write 9
    emit(enc_i(opc_op_imm, 12'd1, 5'd0, 3'b000, 5'd1));
    emit(enc_i(opc_op_imm, 12'd1, 5'd0, 3'b000, 5'd2));
    emit(enc_b(13'd12, 5'd2, 5'd1, 3'b000));
    emit(enc_i(opc_op_imm, 12'd9, 5'd0, 3'b000, 5'd3));
    emit(enc_i(opc_op_imm, 12'd9, 5'd0, 3'b000, 5'd4));
    emit(enc_i(opc_op_imm, 12'd3, 5'd0, 3'b000, 5'd5));
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    emit(enc_i(opc_op_imm, 12'd4, 5'd0, 3'b000, 5'd6));
    emit(enc_b(13'd8, 5'd5, 5'd1, 3'b000));  // beq 1 vs 3 falls through
    emit(enc_j(21'd12, 5'd7));
    emit(enc_i(opc_op_imm, 12'd9, 5'd0, 3'b000, 5'd8));
    emit(enc_i(opc_op_imm, 12'd9, 5'd0, 3'b000, 5'd9));
    emit(enc_i(opc_op_imm, 12'd7, 5'd7, 3'b000, 5'd10));
    emit(enc_b(13'd8, 5'd0, 5'd1, 3'b001));
    emit(enc_i(opc_op_imm, 12'd9, 5'd0, 3'b000, 5'd11));
    emit(ecall_w);
    run_program("branch");

    for (int t = 0; t < 20; t++) begin
      build_random();
      run_program($sformatf("random_%0d", t));
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_hazard.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_pipeline.sv
testbench/rv_tb_properties.sv
testbench/rv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module rv_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrv_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q '\*\* PASS \*\*' sim.log; then
  exit 0
fi
exit 1
